// ==== logic/msoc_pkg.sv ====
// SoC fabric package: region map, register offsets,
// bus request/response structs and UART constants
`default_nettype none

package msoc_pkg;

  ////////////////////////////////////////////////////////////
  // bus geometry and region map
  localparam int unsigned msoc_addr_w    = 32;
  localparam int unsigned msoc_data_w    = 32;
  localparam int unsigned msoc_region_w  = 4;
  localparam int unsigned msoc_n_regions = 16;
  localparam int unsigned msoc_region_lsb = 20; // region in addr[23:20]
  localparam int unsigned msoc_word_lsb  = 2;   // byte offset below

  localparam int unsigned region_ram      = 1;
  localparam int unsigned region_uart_ctl = 2;
  localparam int unsigned region_uart_rx  = 3;
  localparam int unsigned region_gpio     = 7;

  localparam int unsigned ram_words_log2 = 14; // 64 KiB data RAM

  ////////////////////////////////////////////////////////////
  // UART registers
  localparam logic [3:0]  uart_off_tx          = 4'd0;
  localparam logic [3:0]  uart_off_baud        = 4'd1;
  localparam logic [15:0] uart_baud_reset      = 16'd87;
  localparam int unsigned uart_fifo_depth_log2 = 4;

  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [3:0]             be;
    logic [msoc_addr_w-1:0] addr;
    logic [msoc_data_w-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                   gnt;
    logic                   rvalid;
    logic [msoc_data_w-1:0] rdata;
  } bus_rsp_t;

  typedef struct packed {
    logic [10:0]                   pad_hi;
    logic [uart_fifo_depth_log2:0] count;
    logic [2:0]                    pad_lo;
    logic                          full;
    logic                          frame_err;  // of the head entry
    logic                          is_transmitting;
    logic                          is_receiving;
    logic                          not_empty;
    logic [7:0]                    head_byte;
  } uart_status_t;

endpackage

`default_nettype wire

// ==== logic/msoc_bus_decode.sv ====
// one-hot region decoder with same-cycle grant,
// next-cycle rvalid and read-data return mux
`timescale 1ns/1ps
`default_nettype none

module msoc_bus_decode import msoc_pkg::*;
(
  input  logic                      msoc_clk,
  input  logic                      rstn,
  input  bus_req_t                  bus_req_i,
  output logic [msoc_n_regions-1:0] sel_o,
  input  logic [msoc_data_w-1:0]    rdata_regions_i [msoc_n_regions],
  output bus_rsp_t                  bus_rsp_o
);

  logic [msoc_n_regions-1:0] sel_q; // select of the access in flight
  logic                      rvalid_q;
  logic [msoc_data_w-1:0]    rdata_mux;

  always_comb
  begin
    for (int i = 0; i < msoc_n_regions; i++)
    begin
      sel_o[i] = bus_req_i.req &&
                 (bus_req_i.addr[msoc_region_lsb +: msoc_region_w] == msoc_region_w'(i));
    end
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      sel_q    <= '0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      sel_q    <= sel_o;
      rvalid_q <= bus_req_i.req; // every request is granted
    end
  end

  // unmapped regions read as zero, no select bit set
  always_comb
  begin
    rdata_mux = '0;
    for (int i = 0; i < msoc_n_regions; i++)
    begin
      if (sel_q[i])
        rdata_mux |= rdata_regions_i[i];
    end
  end

  assign bus_rsp_o.gnt    = bus_req_i.req; // never stalls
  assign bus_rsp_o.rvalid = rvalid_q;
  assign bus_rsp_o.rdata  = rdata_mux;

endmodule

`default_nettype wire

// ==== logic/msoc_data_ram.sv ====
// word-addressed data RAM, byte-enabled writes, synchronous read
`timescale 1ns/1ps
`default_nettype none

module msoc_data_ram import msoc_pkg::*;
(
  input  logic                   msoc_clk,
  input  logic                   sel_i,
  input  bus_req_t               bus_req_i,
  output logic [msoc_data_w-1:0] rdata_o
);

  logic [msoc_data_w-1:0]    mem [2**ram_words_log2];
  logic [ram_words_log2-1:0] word_idx;

  assign word_idx = bus_req_i.addr[msoc_word_lsb +: ram_words_log2];

  always_ff @(posedge msoc_clk)
  begin
    if (sel_i)
    begin
      if (bus_req_i.we)
      begin
        for (int b = 0; b < msoc_data_w/8; b++)
        begin
          if (bus_req_i.be[b])
            mem[word_idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
        end
      end
      rdata_o <= mem[word_idx]; // old word on a write
    end
  end

endmodule

`default_nettype wire

// ==== logic/uart_rx_fifo.sv ====
// receive FIFO, 16 entries of {frame error, byte},
// with fill count and full/empty flags
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo import msoc_pkg::*;
(
  input  logic                            msoc_clk,
  input  logic                            rstn,
  input  logic                            push_i,
  input  logic [8:0]                      din_i,
  input  logic                            pop_i,
  output logic [8:0]                      dout_o,
  output logic [uart_fifo_depth_log2:0]   count_o,
  output logic                            full_o,
  output logic                            empty_o
);

  logic [8:0]                      buffer [2**uart_fifo_depth_log2];
  logic [uart_fifo_depth_log2-1:0] wr_ptr;
  logic [uart_fifo_depth_log2-1:0] rd_ptr;
  logic [uart_fifo_depth_log2:0]   count_q;
  logic                            do_push;
  logic                            do_pop;

  assign full_o  = count_q[uart_fifo_depth_log2];
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;  // dropped when full
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      count_q <= count_q + (do_push ? 1'b1 : 1'b0) - (do_pop ? 1'b1 : 1'b0);
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (do_push)
      buffer[wr_ptr] <= din_i;
  end

  assign dout_o  = buffer[rd_ptr]; // head entry
  assign count_o = count_q;

endmodule

`default_nettype wire

// ==== logic/uart_core.sv ====
// UART transmitter and receiver with a shared baud divisor;
// receive input is synchronized and majority filtered
`timescale 1ns/1ps
`default_nettype none

module uart_core
(
  input  logic        msoc_clk,
  input  logic        rstn,
  input  logic [15:0] baud_i,
  input  logic        tx_start_i,
  input  logic [7:0]  tx_byte_i,
  input  logic        uart_rx_i,
  output logic        uart_tx_o,
  output logic        rx_valid_o,
  output logic [7:0]  rx_byte_o,
  output logic        rx_err_o,
  output logic        is_transmitting_o,
  output logic        is_receiving_o
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

  logic [1:0]  rx_sync;
  logic [2:0]  rx_samp;
  logic        rx_maj;
  rx_state_e   rx_state;
  logic [15:0] rx_cnt;
  logic [2:0]  rx_bit;
  logic [7:0]  rx_shift;

  logic        tx_busy;
  logic [15:0] tx_cnt;
  logic [3:0]  tx_left;  // bits still to send after the current one
  logic [8:0]  tx_shift; // data bits then stop bit

  assign rx_maj = (rx_samp[0] & rx_samp[1]) | (rx_samp[1] & rx_samp[2]) |
                  (rx_samp[0] & rx_samp[2]);

  ////////////////////////////////////////////////////////////
  // receiver
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rx_sync    <= 2'b11; // idle line is high
      rx_samp    <= 3'b111;
      rx_state   <= RX_IDLE;
      rx_cnt     <= '0;
      rx_bit     <= '0;
      rx_shift   <= '0;
      rx_valid_o <= 1'b0;
      rx_byte_o  <= '0;
      rx_err_o   <= 1'b0;
    end
    else
    begin
      rx_sync    <= {rx_sync[0], uart_rx_i};
      rx_samp    <= {rx_samp[1:0], rx_sync[1]};
      rx_valid_o <= 1'b0;
      case (rx_state)
        RX_IDLE:
          if (!rx_maj)
          begin
            rx_state <= RX_START;
            rx_cnt   <= baud_i >> 1; // aim at the bit middle
          end
        RX_START:
          if (rx_cnt != 0)
            rx_cnt <= rx_cnt - 1'b1;
          else if (!rx_maj)
          begin
            rx_state <= RX_DATA;
            rx_cnt   <= baud_i;
            rx_bit   <= '0;
          end
          else
            rx_state <= RX_IDLE; // glitch, not a start bit
        RX_DATA:
          if (rx_cnt != 0)
            rx_cnt <= rx_cnt - 1'b1;
          else
          begin
            rx_shift <= {rx_maj, rx_shift[7:1]}; // lsb first
            rx_cnt   <= baud_i;
            rx_bit   <= rx_bit + 1'b1;
            if (rx_bit == 3'd7)
              rx_state <= RX_STOP;
          end
        default:
          if (rx_cnt != 0)
            rx_cnt <= rx_cnt - 1'b1;
          else
          begin
            rx_valid_o <= 1'b1;
            rx_byte_o  <= rx_shift;
            rx_err_o   <= !rx_maj; // stop bit must be high
            rx_state   <= RX_IDLE;
          end
      endcase
    end
  end

  assign is_receiving_o = (rx_state != RX_IDLE);

  ////////////////////////////////////////////////////////////
  // transmitter
  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      tx_busy   <= 1'b0;
      tx_cnt    <= '0;
      tx_left   <= '0;
      tx_shift  <= '1;
      uart_tx_o <= 1'b1;
    end
    else if (!tx_busy)
    begin
      if (tx_start_i)
      begin
        tx_busy   <= 1'b1;
        tx_cnt    <= baud_i;
        tx_left   <= 4'd9;
        tx_shift  <= {1'b1, tx_byte_i};
        uart_tx_o <= 1'b0; // start bit
      end
    end
    else if (tx_cnt != 0)
      tx_cnt <= tx_cnt - 1'b1;
    else if (tx_left == 0)
    begin
      tx_busy   <= 1'b0;
      uart_tx_o <= 1'b1;
    end
    else
    begin
      uart_tx_o <= tx_shift[0];
      tx_shift  <= {1'b1, tx_shift[8:1]};
      tx_left   <= tx_left - 1'b1;
      tx_cnt    <= baud_i;
    end
  end

  assign is_transmitting_o = tx_busy;

endmodule

`default_nettype wire

// ==== logic/uart_regs.sv ====
// UART register block: transmit strobe, baud divisor,
// receive FIFO status readback and pop
`timescale 1ns/1ps
`default_nettype none

module uart_regs import msoc_pkg::*;
(
  input  logic                   msoc_clk,
  input  logic                   rstn,
  input  logic                   ctl_sel_i,
  input  logic                   rx_sel_i,
  input  bus_req_t               bus_req_i,
  output logic [msoc_data_w-1:0] rdata_o,
  input  logic                   uart_rx_i,
  output logic                   uart_tx_o
);

  logic                          tx_start;
  logic [7:0]                    tx_byte;
  logic [15:0]                   baud;
  logic                          rx_valid;
  logic [7:0]                    rx_byte;
  logic                          rx_err;
  logic                          is_transmitting;
  logic                          is_receiving;
  logic [8:0]                    fifo_head;
  logic [uart_fifo_depth_log2:0] fifo_count;
  logic                          fifo_full;
  logic                          fifo_empty;
  logic [3:0]                    word_off;
  uart_status_t                  status;

  assign word_off = bus_req_i.addr[msoc_word_lsb +: 4];

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      tx_start <= 1'b0;
      tx_byte  <= '0;
      baud     <= uart_baud_reset;
    end
    else
    begin
      tx_start <= 1'b0; // single cycle strobe
      if (ctl_sel_i && bus_req_i.we)
      begin
        if (word_off == uart_off_tx)
        begin
          tx_start <= 1'b1;
          tx_byte  <= bus_req_i.wdata[7:0];
        end
        else if (word_off == uart_off_baud)
          baud <= bus_req_i.wdata[15:0];
      end
    end
  end

  always_comb
  begin
    status                 = '0;
    status.count           = fifo_count;
    status.full            = fifo_full;
    status.frame_err       = fifo_head[8];
    status.is_transmitting = is_transmitting;
    status.is_receiving    = is_receiving;
    status.not_empty       = !fifo_empty;
    status.head_byte       = fifo_head[7:0];
  end

  always_ff @(posedge msoc_clk)
  begin
    if (rx_sel_i)
      rdata_o <= status;
    else if (ctl_sel_i)
      rdata_o <= {16'b0, baud}; // divisor readback
  end

  uart_core u_core (
    .msoc_clk          (msoc_clk),
    .rstn              (rstn),
    .baud_i            (baud),
    .tx_start_i        (tx_start),
    .tx_byte_i         (tx_byte),
    .uart_rx_i         (uart_rx_i),
    .uart_tx_o         (uart_tx_o),
    .rx_valid_o        (rx_valid),
    .rx_byte_o         (rx_byte),
    .rx_err_o          (rx_err),
    .is_transmitting_o (is_transmitting),
    .is_receiving_o    (is_receiving)
  );

  uart_rx_fifo u_rx_fifo (
    .msoc_clk (msoc_clk),
    .rstn     (rstn),
    .push_i   (rx_valid),
    .din_i    ({rx_err, rx_byte}),
    .pop_i    (rx_sel_i && bus_req_i.we), // any write pops
    .dout_o   (fifo_head),
    .count_o  (fifo_count),
    .full_o   (fifo_full),
    .empty_o  (fifo_empty)
  );

endmodule

`default_nettype wire

// ==== logic/gpio_regs.sv ====
// LED output register and sampled DIP switch readback
`timescale 1ns/1ps
`default_nettype none

module gpio_regs import msoc_pkg::*;
(
  input  logic                   msoc_clk,
  input  logic                   rstn,
  input  logic                   sel_i,
  input  bus_req_t               bus_req_i,
  input  logic [15:0]            dip_i,
  output logic [7:0]             led_o,
  output logic [msoc_data_w-1:0] rdata_o
);

  logic [15:0] dip_q;

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      led_o <= '0;
      dip_q <= '0;
    end
    else
    begin
      dip_q <= dip_i; // sampled every cycle
      if (sel_i && bus_req_i.we)
        led_o <= bus_req_i.wdata[7:0];
    end
  end

  always_ff @(posedge msoc_clk)
  begin
    if (sel_i)
      rdata_o <= {16'b0, dip_q};
  end

endmodule

`default_nettype wire

// ==== logic/msoc_top.sv ====
// SoC fabric top: region decoder, data RAM, UART and GPIO peers
`timescale 1ns/1ps
`default_nettype none

module msoc_top import msoc_pkg::*;
(
  input  logic        msoc_clk,
  input  logic        rstn,
  input  bus_req_t    bus_req_i,
  output bus_rsp_t    bus_rsp_o,
  input  logic        uart_rx_i,
  output logic        uart_tx_o,
  input  logic [15:0] dip_i,
  output logic [7:0]  to_led_o
);

  logic [msoc_n_regions-1:0] sel;
  logic [msoc_data_w-1:0]    region_rdata [msoc_n_regions];
  logic [msoc_data_w-1:0]    ram_rdata;
  logic [msoc_data_w-1:0]    uart_rdata;
  logic [msoc_data_w-1:0]    gpio_rdata;

  always_comb
  begin
    for (int i = 0; i < msoc_n_regions; i++)
      region_rdata[i] = '0; // unused regions
    region_rdata[region_ram]      = ram_rdata;
    region_rdata[region_uart_ctl] = uart_rdata;
    region_rdata[region_uart_rx]  = uart_rdata;
    region_rdata[region_gpio]     = gpio_rdata;
  end

  msoc_bus_decode u_decode (
    .msoc_clk        (msoc_clk),
    .rstn            (rstn),
    .bus_req_i       (bus_req_i),
    .sel_o           (sel),
    .rdata_regions_i (region_rdata),
    .bus_rsp_o       (bus_rsp_o)
  );

  msoc_data_ram u_ram (
    .msoc_clk  (msoc_clk),
    .sel_i     (sel[region_ram]),
    .bus_req_i (bus_req_i),
    .rdata_o   (ram_rdata)
  );

  uart_regs u_uart (
    .msoc_clk  (msoc_clk),
    .rstn      (rstn),
    .ctl_sel_i (sel[region_uart_ctl]),
    .rx_sel_i  (sel[region_uart_rx]),
    .bus_req_i (bus_req_i),
    .rdata_o   (uart_rdata),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o)
  );

  gpio_regs u_gpio (
    .msoc_clk  (msoc_clk),
    .rstn      (rstn),
    .sel_i     (sel[region_gpio]),
    .bus_req_i (bus_req_i),
    .dip_i     (dip_i),
    .led_o     (to_led_o),
    .rdata_o   (gpio_rdata)
  );

endmodule

`default_nettype wire

// ==== verification/msoc_tb_clk.sv ====
// testbench clock (4 ns period) and active-low reset generator
`timescale 1ns/1ps
`default_nettype none

module msoc_tb_clk
(
  output logic msoc_clk_o,
  output logic rstn_o
);

  initial
  begin
    msoc_clk_o = 1'b0;
    forever #2 msoc_clk_o = ~msoc_clk_o;
  end

  initial
  begin
    rstn_o = 1'b0;
    repeat (5) @(posedge msoc_clk_o);
    @(negedge msoc_clk_o); // release away from the active edge
    rstn_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/msoc_tb.sv ====
// directed testbench for the SoC fabric covering RAM, response timing,
// GPIO and UART loopback through the receive FIFO
`timescale 1ns/1ps
`default_nettype none

module msoc_tb import msoc_pkg::*;
();

  localparam int unsigned clk_period_ns = 4;
  localparam int unsigned tb_baud       = 7;
  localparam int unsigned n_frames      = 4;     // loopback frame plus three ordering frames
  localparam int unsigned margin_ns     = 20000; // reset and bus traffic
  localparam int unsigned limit_ns      =
    n_frames * 10 * (tb_baud + 1) * clk_period_ns + margin_ns;

  logic        msoc_clk;
  logic        rstn;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  logic        uart_line; // tx looped back to rx
  logic [15:0] dip;
  logic [7:0]  leds;
  integer      seed;

  msoc_tb_clk u_clk (
    .msoc_clk_o (msoc_clk),
    .rstn_o     (rstn)
  );

  msoc_top dut (
    .msoc_clk  (msoc_clk),
    .rstn      (rstn),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .uart_rx_i (uart_line),
    .uart_tx_o (uart_line),
    .dip_i     (dip),
    .to_led_o  (leds)
  );

  ////////////////////////////////////////////////////////////
  // checking and bus access
  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    if (actual !== expected)
    begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  function automatic logic [31:0] region_addr(input int unsigned region,
                                              input int unsigned word);
    logic [31:0] a;
    a        = '0;
    a[23:20] = region[3:0];
    a[19:2]  = word[17:0];
    return a;
  endfunction

  // grant must follow the request in the same cycle
  task automatic drive_req(input logic we, input logic [3:0] be, input logic [31:0] addr,
                           input logic [31:0] wdata);
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.be    = be;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    #1;
    check_eq(bus_rsp.gnt, 1'b1, "grant in request cycle");
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be);
    @(negedge msoc_clk);
    drive_req(1'b1, be, addr, wdata);
    @(negedge msoc_clk);
    check_eq(bus_rsp.rvalid, 1'b1, "rvalid after write");
    bus_req.req = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    @(negedge msoc_clk);
    drive_req(1'b0, 4'hf, addr, 32'h0);
    @(negedge msoc_clk);
    check_eq(bus_rsp.rvalid, 1'b1, "rvalid after read");
    data        = bus_rsp.rdata;
    bus_req.req = 1'b0;
  endtask

  task automatic read_status(output logic [31:0] st);
    bus_read(region_addr(region_uart_rx, 0), st);
    check_eq(st[31:21], 0, "status upper padding");
    check_eq(st[15:13], 0, "status lower padding");
  endtask

  // send one byte and wait until the transmitter is idle again
  task automatic uart_send(input logic [7:0] data);
    logic [31:0] st;
    bus_write(region_addr(region_uart_ctl, uart_off_tx), {24'b0, data}, 4'hf);
    st = 32'h400;
    while (st[10])
      read_status(st); // is_transmitting
  endtask

  // sample each bit of one frame in its middle
  task automatic check_tx_frame(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0}; // stop bit down to start bit
    while (uart_line !== 1'b0)
      @(negedge msoc_clk);
    repeat ((tb_baud + 1) / 2) @(negedge msoc_clk);
    for (int k = 0; k < 10; k++)
    begin
      check_eq(uart_line, frame[k], "tx frame bit at its middle");
      repeat (tb_baud + 1) @(negedge msoc_clk);
    end
  endtask

  task automatic wait_rx_count(input int unsigned n, output logic [31:0] st);
    read_status(st);
    while (st[20:16] < n)
      read_status(st);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  task automatic test_ram();
    logic [15:0] idx     [8];
    logic [31:0] model   [8];
    logic [3:0]  be_list [8];
    logic [31:0] wdata;
    logic [31:0] rdata;
    be_list = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000, 4'b1111, 4'b0101, 4'b1100};
    for (int i = 0; i < 8; i++)
    begin
      idx[i]   = ($random(seed) & 16'h3ff0) | i; // low bits keep words distinct
      model[i] = $random(seed);
      bus_write(region_addr(region_ram, idx[i]), model[i], 4'hf);
    end
    for (int i = 0; i < 8; i++)
    begin
      bus_read(region_addr(region_ram, idx[i]), rdata);
      check_eq(rdata, model[i], "RAM full word readback");
    end
    for (int i = 0; i < 8; i++)
    begin
      wdata = $random(seed);
      bus_write(region_addr(region_ram, idx[i]), wdata, be_list[i]);
      for (int b = 0; b < 4; b++)
      begin
        if (be_list[i][b])
          model[i][8*b +: 8] = wdata[8*b +: 8];
      end
    end
    for (int i = 0; i < 8; i++)
    begin
      bus_read(region_addr(region_ram, idx[i]), rdata);
      check_eq(rdata, model[i], "RAM byte-enabled readback");
    end
  endtask

  // one request per cycle with each response checked a cycle later
  task automatic test_timing();
    logic [31:0] addr     [5];
    logic        we       [5];
    logic [31:0] exp_data [5];
    logic [31:0] word;
    word     = $random(seed);
    addr     = '{region_addr(region_ram, 5), region_addr(region_ram, 5),
                 region_addr(12, 0), region_addr(12, 3), region_addr(region_ram, 5)};
    we       = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
    exp_data = '{32'h0, word, 32'h0, 32'h0, word};
    @(negedge msoc_clk);
    for (int i = 0; i <= 5; i++)
    begin
      if (i > 0)
      begin
        check_eq(bus_rsp.rvalid, 1'b1, "rvalid on back-to-back request");
        if (!we[i-1])
          check_eq(bus_rsp.rdata, exp_data[i-1], "back-to-back read data");
      end
      if (i < 5)
        drive_req(we[i], 4'hf, addr[i], word);
      else
        bus_req.req = 1'b0;
      @(negedge msoc_clk);
    end
    check_eq(bus_rsp.rvalid, 1'b0, "rvalid low with no request");
  endtask

  task automatic test_gpio();
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [15:0] dip_val;
    wdata = $random(seed);
    bus_write(region_addr(region_gpio, 0), wdata, 4'hf);
    check_eq(leds, wdata[7:0], "LED output after write");
    dip_val = $random(seed);
    @(negedge msoc_clk);
    dip = dip_val;
    repeat (2) @(negedge msoc_clk); // let the sampling register settle
    bus_read(region_addr(region_gpio, 0), rdata);
    check_eq(rdata, {16'b0, dip_val}, "DIP switch readback");
  endtask

  task automatic test_uart_loopback();
    logic [7:0]  data;
    logic [31:0] st;
    bus_write(region_addr(region_uart_ctl, uart_off_baud), tb_baud, 4'hf);
    data = $random(seed);
    bus_write(region_addr(region_uart_ctl, uart_off_tx), {24'b0, data}, 4'hf);
    check_tx_frame(data);
    wait_rx_count(1, st);
    check_eq(st[8], 1'b1, "not_empty after one frame");
    check_eq(st[7:0], data, "received byte");
    check_eq(st[11], 1'b0, "frame error of received byte");
    check_eq(st[20:16], 1, "fill count after one frame");
    bus_write(region_addr(region_uart_rx, 0), 32'h0, 4'hf); // pop
    read_status(st);
    check_eq(st[20:16], 0, "fill count after pop");
    check_eq(st[8], 1'b0, "not_empty after pop");
  endtask

  task automatic test_fifo_order();
    logic [7:0]  sent [3];
    logic [31:0] st;
    for (int i = 0; i < 3; i++)
    begin
      sent[i] = $random(seed);
      uart_send(sent[i]);
    end
    wait_rx_count(3, st);
    check_eq(st[20:16], 3, "fill count after three frames");
    for (int i = 0; i < 3; i++)
    begin
      read_status(st);
      check_eq(st[7:0], sent[i], "FIFO order of received bytes");
      check_eq(st[11], 1'b0, "frame error in FIFO");
      bus_write(region_addr(region_uart_rx, 0), 32'h0, 4'hf);
    end
    read_status(st);
    check_eq(st[8], 1'b0, "FIFO empty after three pops");
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  initial
  begin
    seed    = 32'h98308b23;
    bus_req = '0;
    dip     = '0;
    wait (rstn === 1'b1);
    check_eq(uart_line, 1'b1, "tx line idle after reset");
    check_eq(leds, 8'h0, "LEDs after reset");
    check_eq(bus_rsp.rvalid, 1'b0, "rvalid after reset");
    check_eq(bus_rsp.gnt, 1'b0, "gnt after reset");
    test_ram();
    test_timing();
    test_gpio();
    test_uart_loopback();
    test_fifo_order();
    $display("TEST PASS");
    $finish;
  end

  initial
  begin
    #(limit_ns);
    $display("Timeout: the tests did not finish within %0d ns", limit_ns);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/msoc_pkg.sv
logic/msoc_bus_decode.sv
logic/msoc_data_ram.sv
logic/uart_rx_fifo.sv
logic/uart_core.sv
logic/uart_regs.sv
logic/gpio_regs.sv
logic/msoc_top.sv
verification/msoc_tb_clk.sv
verification/msoc_tb.sv

// ==== Bender.yml ====
package:
  name: msoc_fabric

sources:
  - logic/msoc_pkg.sv
  - logic/msoc_bus_decode.sv
  - logic/msoc_data_ram.sv
  - logic/uart_rx_fifo.sv
  - logic/uart_core.sv
  - logic/uart_regs.sv
  - logic/gpio_regs.sv
  - logic/msoc_top.sv
  - target: test
    files:
      - verification/msoc_tb_clk.sv
      - verification/msoc_tb.sv
